// File: common/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data word and shared bus width.
`define WORD_WIDTH    32
`define REG_COUNT     16
`define REG_SEL_WIDTH 4

// instruction field positions.
`define OP_MSB  31
`define OP_LSB  27
`define RA_MSB  26
`define RA_LSB  23
`define RB_MSB  22
`define RB_LSB  19
`define RC_MSB  18
`define RC_LSB  15
`define IMM_MSB 18

`endif

// File: common/cpuIsaPkg.sv
`include "cpu_macros.svh"

package cpuIsaPkg;

	// opcode field, codes not listed run as a nop.
	typedef enum logic [`OP_MSB-`OP_LSB:0] {
		opNop  = 5'd0,
		opAdd  = 5'd1,
		opSub  = 5'd2,
		opAnd  = 5'd3,
		opOr   = 5'd4,
		opAddi = 5'd5,
		opAndi = 5'd6,
		opOri  = 5'd7,
		opLdi  = 5'd8,
		opOut  = 5'd9
	} opcodeT;

	// register index in the Ra, Rb and Rc fields.
	typedef logic [`REG_SEL_WIDTH-1:0] regSelT;

	// raw immediate field before sign extension.
	typedef logic [`IMM_MSB:0] immT;

	typedef logic [`WORD_WIDTH-1:0] wordT;

endpackage

// File: common/cpuCtrlPkg.sv
package cpuCtrlPkg;

	// control steps of one instruction.
	typedef enum logic [2:0] {
		stFetch   = 3'd0,
		stT1      = 3'd1,
		stT2      = 3'd2,
		stT3      = 3'd3,
		stOutWait = 3'd4
	} stepT;

	// operations of the ALU, result is Y op bus.
	typedef enum logic [1:0] {
		aluAdd = 2'd0,
		aluSub = 2'd1,
		aluAnd = 2'd2,
		aluOr  = 2'd3
	} aluOpT;

endpackage

// File: source/selectEncode.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module selectEncode (
	input  logic [`WORD_WIDTH-1:0] ir,
	input  logic                   gra,
	input  logic                   grb,
	input  logic                   grc,
	input  logic                   rin,
	input  logic                   rout,
	input  logic                   baout,
	output logic [`REG_COUNT-1:0]  regIn,
	output logic [`REG_COUNT-1:0]  regOut
);
	import cpuIsaPkg::*;

	regSelT                 fieldSel;
	logic                   anySel;
	logic                   zeroBase;
	logic [`REG_COUNT-1:0]  decoded;

	// field priority is Ra, then Rb, then Rc.
	always_comb begin
		if (gra)
			fieldSel = ir[`RA_MSB:`RA_LSB];
		else if (grb)
			fieldSel = ir[`RB_MSB:`RB_LSB];
		else
			fieldSel = ir[`RC_MSB:`RC_LSB];
	end

	assign anySel  = gra | grb | grc;
	assign decoded = anySel ? (`REG_COUNT'(1) << fieldSel) : '0;

	// base address of R0 reads as zero.
	assign zeroBase = baout && (fieldSel == '0);

	assign regIn  = rin ? decoded : '0;
	assign regOut = ((rout || baout) && !zeroBase) ? decoded : '0;

endmodule

// File: datapath/registerFile.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module registerFile (
	input  logic                   clock,
	input  logic                   arstN,
	input  logic [`WORD_WIDTH-1:0] bus,
	input  logic [`REG_COUNT-1:0]  regIn,
	input  logic [`REG_COUNT-1:0]  regOut,
	output logic [`WORD_WIDTH-1:0] regData
);

	logic [`WORD_WIDTH-1:0] regs [`REG_COUNT];

	// one register per set bit of regIn.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				if (regIn[i]) begin
					regs[i] <= bus;
				end
			end
		end
	end

	// wired-or read, zero when nothing is enabled.
	always_comb begin
		regData = '0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			if (regOut[i]) begin
				regData = regData | regs[i];
			end
		end
	end

endmodule

// File: datapath/aluUnit.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module aluUnit (
	input  logic                   clock,
	input  logic                   arstN,
	input  logic [`WORD_WIDTH-1:0] bus,
	input  logic                   yIn,
	input  logic                   zIn,
	input  cpuCtrlPkg::aluOpT      aluOp,
	output logic [`WORD_WIDTH-1:0] zData
);
	import cpuCtrlPkg::*;

	logic [`WORD_WIDTH-1:0] yReg;
	logic [`WORD_WIDTH-1:0] zReg;
	logic [`WORD_WIDTH-1:0] result;

	// Y is the first operand, the bus the second.
	always_comb begin
		case (aluOp)
			aluAdd:  result = yReg + bus;
			aluSub:  result = yReg - bus;
			aluAnd:  result = yReg & bus;
			aluOr:   result = yReg | bus;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			yReg <= '0;
			zReg <= '0;
		end else begin
			if (yIn) begin
				yReg <= bus;
			end
			if (zIn) begin
				zReg <= result;
			end
		end
	end

	assign zData = zReg;

endmodule

// File: control/controlUnit.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module controlUnit (
	input  logic                   clock,
	input  logic                   arstN,
	input  logic [`WORD_WIDTH-1:0] instrData,
	input  logic                   instrValid,
	output logic                   instrReady,
	input  logic [`WORD_WIDTH-1:0] bus,
	output logic [`WORD_WIDTH-1:0] outData,
	output logic                   outValid,
	input  logic                   outReady,
	output logic [`WORD_WIDTH-1:0] ir,
	output logic                   gra,
	output logic                   grb,
	output logic                   grc,
	output logic                   rin,
	output logic                   rout,
	output logic                   baout,
	output logic                   yIn,
	output logic                   zIn,
	output logic                   zOut,
	output logic                   cOut,
	output cpuCtrlPkg::aluOpT      aluOp
);
	import cpuIsaPkg::*;
	import cpuCtrlPkg::*;

	stepT   step;
	opcodeT op;
	logic   isAlu;
	logic   isImm;

	assign op    = opcodeT'(ir[`OP_MSB:`OP_LSB]);
	assign isImm = (op == opAddi) || (op == opAndi) || (op == opOri) || (op == opLdi);
	assign isAlu = isImm || (op == opAdd) || (op == opSub) || (op == opAnd) || (op == opOr);

	assign instrReady = (step == stFetch);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			step     <= stFetch;
			ir       <= '0;
			outData  <= '0;
			outValid <= 1'b0;
		end else begin
			case (step)
				stFetch: begin
					if (instrValid) begin
						ir   <= instrData;
						step <= stT1;
					end
				end
				stT1: begin
					if (isAlu) begin
						step <= stT2;
					end else if (op == opOut) begin
						// R[Ra] is on the bus this step.
						outData  <= bus;
						outValid <= 1'b1;
						step     <= stOutWait;
					end else begin
						step <= stFetch;
					end
				end
				stT2:    step <= stT3;
				stT3:    step <= stFetch;
				stOutWait: begin
					if (outReady) begin
						outValid <= 1'b0;
						step     <= stFetch;
					end
				end
				default: step <= stFetch;
			endcase
		end
	end

	// strobes per step.
	always_comb begin
		{gra, grb, grc, rin, rout, baout, yIn, zIn, zOut, cOut} = '0;
		case (op)
			opSub, opAnd, opAndi: aluOp = (op == opSub) ? aluSub : aluAnd;
			opOr, opOri:          aluOp = aluOr;
			default:              aluOp = aluAdd;
		endcase
		case (step)
			stT1: begin
				gra   = (op == opOut);
				grb   = isAlu;
				rout  = (op == opOut) || (isAlu && op != opLdi);
				baout = (op == opLdi);
				yIn   = isAlu;
			end
			stT2: begin
				grc  = !isImm;
				rout = !isImm;
				cOut = isImm;
				zIn  = 1'b1;
			end
			stT3: begin
				zOut = 1'b1;
				gra  = 1'b1;
				rin  = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: source/cpuTop.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module cpuTop (
	input  logic                   clock,
	input  logic                   arstN,
	input  logic [`WORD_WIDTH-1:0] instrData,
	input  logic                   instrValid,
	output logic                   instrReady,
	output logic [`WORD_WIDTH-1:0] outData,
	output logic                   outValid,
	input  logic                   outReady
);
	import cpuIsaPkg::*;
	import cpuCtrlPkg::*;

	wordT                  ir;
	wordT                  bus;
	wordT                  regData;
	wordT                  zData;
	wordT                  immExt;
	immT                   immField;
	logic                  gra, grb, grc;
	logic                  rin, rout, baout;
	logic                  yIn, zIn, zOut, cOut;
	aluOpT                 aluOp;
	logic [`REG_COUNT-1:0] regIn;
	logic [`REG_COUNT-1:0] regOut;

	// sign-extended 19-bit immediate.
	assign immField = ir[`IMM_MSB:0];
	assign immExt   = {{(`WORD_WIDTH - `IMM_MSB - 1){immField[`IMM_MSB]}}, immField};

	// Z wins, then C, then the registers.
	assign bus = zOut ? zData : (cOut ? immExt : regData);

	controlUnit u_controlUnit (
		.clock(clock), .arstN(arstN),
		.instrData(instrData), .instrValid(instrValid), .instrReady(instrReady),
		.bus(bus),
		.outData(outData), .outValid(outValid), .outReady(outReady),
		.ir(ir),
		.gra(gra), .grb(grb), .grc(grc), .rin(rin), .rout(rout), .baout(baout),
		.yIn(yIn), .zIn(zIn), .zOut(zOut), .cOut(cOut),
		.aluOp(aluOp)
	);

	selectEncode u_selectEncode (
		.ir(ir), .gra(gra), .grb(grb), .grc(grc),
		.rin(rin), .rout(rout), .baout(baout),
		.regIn(regIn), .regOut(regOut)
	);

	registerFile u_registerFile (
		.clock(clock), .arstN(arstN), .bus(bus),
		.regIn(regIn), .regOut(regOut), .regData(regData)
	);

	aluUnit u_aluUnit (
		.clock(clock), .arstN(arstN), .bus(bus),
		.yIn(yIn), .zIn(zIn), .aluOp(aluOp), .zData(zData)
	);

endmodule

// File: verif/tbClock.sv
`timescale 1ns/100ps

module tbClock (
	output logic clock,
	output logic arstN
);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// reset held for three cycles, released on a falling edge.
	initial begin
		arstN = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;
	end

endmodule

// File: verif/cpuTop_assert.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module cpuTopAssert (
	input logic                   clock,
	input logic                   arstN,
	input logic [`WORD_WIDTH-1:0] instrData,
	input logic                   instrValid,
	input logic                   instrReady,
	input logic [`WORD_WIDTH-1:0] outData,
	input logic                   outValid,
	input logic                   outReady,
	input logic [`REG_COUNT-1:0]  regIn,
	input logic [`REG_COUNT-1:0]  regOut
);

	// an offered instruction is held until accepted.
	instrHeld: assert property (@(posedge clock) disable iff (!arstN)
		instrValid && !instrReady |=> instrValid && $stable(instrData))
		else $error("instruction changed before it was accepted");

	outHeld: assert property (@(posedge clock) disable iff (!arstN)
		outValid && !outReady |=> outValid && $stable(outData))
		else $error("output word dropped or changed before outReady");

	// one register at most, never read and written in the same step.
	enablesOneHot: assert property (@(posedge clock) disable iff (!arstN)
		$onehot0(regIn) && $onehot0(regOut) && !((|regIn) && (|regOut)))
		else $error("register enables are not one-hot or zero, or overlap");

endmodule

bind cpuTop cpuTopAssert u_cpuTopAssert (
	.clock(clock), .arstN(arstN),
	.instrData(instrData), .instrValid(instrValid), .instrReady(instrReady),
	.outData(outData), .outValid(outValid), .outReady(outReady),
	.regIn(regIn), .regOut(regOut)
);

// File: verif/cpuTopTb.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module cpuTopTb;
	import cpuIsaPkg::*;

	localparam int ROWS   = 28;
	localparam int CLK_NS = 10;

	typedef struct packed {
		opcodeT op;
		regSelT ra;
		regSelT rb;
		regSelT rc;
		immT    imm;
		wordT   expWord;
	} rowT;

	logic clock;
	logic arstN;
	wordT instrData;
	logic instrValid;
	logic instrReady;
	wordT outData;
	logic outValid;
	logic outReady;

	rowT  rows [ROWS];
	wordT expQ [$];
	int   seed = 8297;
	int   errorCount = 0;
	int   checkCount = 0;
	int   transfers = 0;
	int   outRows = 0;

	tbClock u_tbClock (.clock(clock), .arstN(arstN));

	cpuTop u_cpuTop (
		.clock(clock), .arstN(arstN),
		.instrData(instrData), .instrValid(instrValid), .instrReady(instrReady),
		.outData(outData), .outValid(outValid), .outReady(outReady)
	);

	function automatic rowT makeRow(input opcodeT op, input regSelT ra, input regSelT rb,
		input regSelT rc, input immT imm, input wordT expWord);
		return '{op, ra, rb, rc, imm, expWord};
	endfunction

	// Rc shares bits with the immediate, unused fields are zero.
	function automatic wordT encode(input rowT r);
		wordT word;
		word = {r.op, r.ra, r.rb, r.imm};
		word[`RC_MSB:`RC_LSB] = word[`RC_MSB:`RC_LSB] | r.rc;
		return word;
	endfunction

	task automatic checkData(input string what, input wordT got, input wordT exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkFlag(input string what, input logic got, input logic exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// called on a falling edge, returns on the falling edge after the accept.
	task automatic offerInstr(input wordT word);
		instrData  = word;
		instrValid = 1'b1;
		while (!instrReady) @(negedge clock);
		@(negedge clock);
		instrValid = 1'b0;
	endtask

	task automatic fillRows();
		rows[0]  = makeRow(opOut, 5, 0, 0, 0, 32'h0000_0000);
		// R0 nonzero, so a zero base must not read it.
		rows[1]  = makeRow(opLdi, 0, 0, 0, 19'd48, 0);
		rows[2]  = makeRow(opLdi, 1, 0, 0, 19'd100, 0);
		rows[3]  = makeRow(opLdi, 2, 0, 0, 19'h7FFF9, 0);
		rows[4]  = makeRow(opLdi, 3, 1, 0, 19'd20, 0);
		rows[5]  = makeRow(opOut, 1, 0, 0, 0, 32'h0000_0064);
		rows[6]  = makeRow(opOut, 2, 0, 0, 0, 32'hFFFF_FFF9);
		rows[7]  = makeRow(opOut, 3, 0, 0, 0, 32'h0000_0078);
		rows[8]  = makeRow(opAdd, 4, 1, 2, 0, 0);
		rows[9]  = makeRow(opSub, 5, 2, 1, 0, 0);
		rows[10] = makeRow(opAnd, 6, 2, 1, 0, 0);
		rows[11] = makeRow(opOr, 7, 1, 3, 0, 0);
		rows[12] = makeRow(opSub, 8, 0, 1, 0, 0);
		rows[13] = makeRow(opOut, 4, 0, 0, 0, 32'h0000_005D);
		rows[14] = makeRow(opOut, 5, 0, 0, 0, 32'hFFFF_FF95);
		rows[15] = makeRow(opOut, 6, 0, 0, 0, 32'h0000_0060);
		rows[16] = makeRow(opOut, 7, 0, 0, 0, 32'h0000_007C);
		rows[17] = makeRow(opOut, 8, 0, 0, 0, 32'hFFFF_FFCC);
		rows[18] = makeRow(opAddi, 9, 2, 0, 19'h7FFFF, 0);
		rows[19] = makeRow(opAndi, 10, 2, 0, 19'h0F0F0, 0);
		rows[20] = makeRow(opOri, 11, 1, 0, 19'h40000, 0);
		rows[21] = makeRow(opOut, 9, 0, 0, 0, 32'hFFFF_FFF8);
		rows[22] = makeRow(opOut, 10, 0, 0, 0, 32'h0000_F0F0);
		rows[23] = makeRow(opOut, 11, 0, 0, 0, 32'hFFFC_0064);
		rows[24] = makeRow(opNop, 1, 2, 3, 0, 0);
		rows[25] = makeRow(opcodeT'(5'd31), 4, 2, 3, 0, 0);
		rows[26] = makeRow(opOut, 1, 0, 0, 0, 32'h0000_0064);
		rows[27] = makeRow(opOut, 4, 0, 0, 0, 32'h0000_005D);
	endtask

	// output side, random back-pressure and transfer checks.
	initial begin : outputSide
		logic [31:0] rnd;
		outReady = 1'b0;
		forever begin
			@(negedge clock);
			rnd = $random(seed);
			outReady = rnd[0];
			if (outValid) begin
				checkFlag("instrReady while output pending", instrReady, 1'b0);
			end
			// both high here means a transfer on the next rising edge.
			if (outValid && outReady) begin
				transfers++;
				if (expQ.size() == 0) begin
					errorCount++;
					$display("output transfer of %h at %0t with no out instruction pending",
						outData, $time);
				end else begin
					checkData("outData", outData, expQ.pop_front());
				end
			end
		end
	end

	initial begin : mainFlow
		instrData  = '0;
		instrValid = 1'b0;
		fillRows();
		@(posedge arstN);
		@(negedge clock);
		checkFlag("instrReady after reset", instrReady, 1'b1);
		checkFlag("outValid after reset", outValid, 1'b0);
		for (int i = 0; i < ROWS; i++) begin
			if (rows[i].op == opOut) begin
				expQ.push_back(rows[i].expWord);
				outRows++;
			end
			offerInstr(encode(rows[i]));
		end
		while (expQ.size() != 0 || !instrReady) @(negedge clock);
		if (transfers != outRows) begin
			errorCount++;
			$display("saw %0d output transfers where %0d out instructions were sent",
				transfers, outRows);
		end
		$display("checks %0d, errors %0d, transfers %0d", checkCount, errorCount, transfers);
		if (errorCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// about twenty cycles per row is ample even with back-pressure.
	initial begin : watchdog
		#(ROWS * 20 * CLK_NS);
		$display("timeout: the run did not finish within %0d ns", ROWS * 20 * CLK_NS);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: compile.f
+incdir+common
common/cpuIsaPkg.sv
common/cpuCtrlPkg.sv
source/selectEncode.sv
datapath/registerFile.sv
datapath/aluUnit.sv
control/controlUnit.sv
source/cpuTop.sv
verif/tbClock.sv
verif/cpuTop_assert.sv
verif/cpuTopTb.sv

// File: Makefile
TOP = cpuTopTb

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "STATUS: PASS" sim.log && ! grep -q "STATUS: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
